/* logic/cpuPkg.sv */
// Shared widths, opcodes, APB address map, FSM state codes
// and the instruction word formats
`default_nettype none

package cpuPkg;

  localparam int dataWidth    = 16;
  localparam int regCount     = 8;
  localparam int regIdxWidth  = 3;
  localparam int memDepth     = 256;
  localparam int memAddrWidth = 8;
  localparam int apbAddrWidth = 12;

  localparam logic [3:0] opAnd  = 4'd0;
  localparam logic [3:0] opAdd  = 4'd1;
  localparam logic [3:0] opSub  = 4'd2;
  localparam logic [3:0] opAddi = 4'd3;
  localparam logic [3:0] opAndi = 4'd4;
  localparam logic [3:0] opLw   = 4'd5;
  localparam logic [3:0] opSw   = 4'd7;  // 6 is unassigned
  localparam logic [3:0] opBgt  = 4'd8;
  localparam logic [3:0] opBlt  = 4'd9;
  localparam logic [3:0] opBeq  = 4'd10;
  localparam logic [3:0] opBne  = 4'd11;
  localparam logic [3:0] opJmp  = 4'd12;
  localparam logic [3:0] opHalt = 4'd14;
  localparam logic [3:0] opSv   = 4'd15;

  // APB region in paddr[9:8], index in paddr[7:0]
  localparam logic [1:0] regionInstr = 2'd0;
  localparam logic [1:0] regionData  = 2'd1;
  localparam logic [1:0] regionRegs  = 2'd2;
  localparam logic [1:0] regionCtrl  = 2'd3;
  localparam logic [7:0] ctrlIndex   = 8'd0;

  localparam logic [2:0] stIdle      = 3'd0;
  localparam logic [2:0] stFetch     = 3'd1;
  localparam logic [2:0] stDecode    = 3'd2;
  localparam logic [2:0] stExecute   = 3'd3;
  localparam logic [2:0] stMemory    = 3'd4;
  localparam logic [2:0] stWriteBack = 3'd5;

  typedef union packed {
    struct packed {
      logic [3:0] opcode;
      logic [2:0] rd;
      logic [2:0] rs1;
      logic [2:0] rs2;
      logic [2:0] unused;
    } rFormat;
    struct packed {
      logic [3:0] opcode;
      logic       mode;  // Branches compare against zero when set
      logic [2:0] rd;
      logic [2:0] rs1;
      logic [4:0] imm;
    } iFormat;
    struct packed {
      logic [3:0]  opcode;
      logic [11:0] offset;
    } jFormat;
    struct packed {
      logic [3:0] opcode;
      logic [2:0] rs1;
      logic [8:0] imm;
    } sFormat;
  } instrWord;

endpackage

`default_nettype wire

/* logic/alu.sv */
// ALU for and, add, sub and the unsigned branch compares
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [3:0]                    aluOp,
  input  logic [cpuPkg::dataWidth-1:0]  a,
  input  logic [cpuPkg::dataWidth-1:0]  b,
  output logic [cpuPkg::dataWidth-1:0]  result,
  output logic                          taken
);

  always_comb begin
    case (aluOp)
      cpuPkg::opAnd, cpuPkg::opAndi: result = a & b;
      cpuPkg::opSub:                 result = a - b;
      default:                       result = a + b;  // Also load and store addresses
    endcase
  end

  always_comb begin
    case (aluOp)
      cpuPkg::opBgt: taken = (a > b);
      cpuPkg::opBlt: taken = (a < b);
      cpuPkg::opBeq: taken = (a == b);
      cpuPkg::opBne: taken = (a != b);
      default:       taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/apbSlave.sv */
// APB slave with address decode, access error rules, start pulse and status
`timescale 1ns/1ps
`default_nettype none

module apbSlave (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [cpuPkg::apbAddrWidth-1:0]   paddr,
  input  logic [cpuPkg::dataWidth-1:0]      pwdata,
  output logic [cpuPkg::dataWidth-1:0]      prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  logic                              busy,
  output logic                              start,
  output logic                              instrWe,
  output logic                              dataWe,
  output logic [cpuPkg::memAddrWidth-1:0]   hostIndex,
  output logic [cpuPkg::dataWidth-1:0]      hostWdata,
  input  logic [cpuPkg::dataWidth-1:0]      instrRdata,
  input  logic [cpuPkg::dataWidth-1:0]      dataRdata,
  input  logic [cpuPkg::dataWidth-1:0]      regRdata
);

  logic [1:0] region;
  logic       access;
  logic       accessError;
  logic       writeOk;
  logic       coreActive;

  assign region     = paddr[9:8];
  assign hostIndex  = paddr[7:0];
  assign hostWdata  = pwdata;
  assign access     = psel && penable;
  assign coreActive = busy || start;  // Covers the cycle before the first fetch
  assign pready     = 1'b1;           // Zero wait states

  always_comb begin
    case (region)
      cpuPkg::regionInstr, cpuPkg::regionData: accessError = coreActive;
      cpuPkg::regionRegs: accessError = pwrite || (hostIndex >= cpuPkg::regCount);
      default: accessError = (hostIndex != cpuPkg::ctrlIndex) || (pwrite && coreActive);
    endcase
  end

  assign pslverr = access && accessError;
  assign writeOk = access && pwrite && !accessError;
  assign instrWe = writeOk && (region == cpuPkg::regionInstr);
  assign dataWe  = writeOk && (region == cpuPkg::regionData);

  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= writeOk && (region == cpuPkg::regionCtrl) && pwdata[0];  // One cycle only
    end
  end

  always_comb begin
    case (region)
      cpuPkg::regionInstr: prdata = instrRdata;
      cpuPkg::regionData:  prdata = dataRdata;
      cpuPkg::regionRegs:  prdata = regRdata;
      default:             prdata = {{(cpuPkg::dataWidth-1){1'b0}}, coreActive};  // Busy bit
    endcase
  end

endmodule

`default_nettype wire

/* logic/memorySystem.sv */
// Instruction and data memories, shared between the APB host and the core
`timescale 1ns/1ps
`default_nettype none

module memorySystem (
  input  logic                              clk,
  input  logic                              instrWe,
  input  logic                              dataWe,
  input  logic [cpuPkg::memAddrWidth-1:0]   hostIndex,
  input  logic [cpuPkg::dataWidth-1:0]      hostWdata,
  output logic [cpuPkg::dataWidth-1:0]      instrRdata,
  output logic [cpuPkg::dataWidth-1:0]      dataRdata,
  input  logic [cpuPkg::memAddrWidth-1:0]   pc,
  output logic [cpuPkg::dataWidth-1:0]      instruction,
  input  logic                              coreDataWe,
  input  logic [cpuPkg::memAddrWidth-1:0]   coreAddr,
  input  logic [cpuPkg::dataWidth-1:0]      coreWdata,
  output logic [cpuPkg::dataWidth-1:0]      coreRdata,
  input  logic                              busy
);

  logic [cpuPkg::dataWidth-1:0]    instrMem [cpuPkg::memDepth];
  logic [cpuPkg::dataWidth-1:0]    dataMem  [cpuPkg::memDepth];
  logic [cpuPkg::memAddrWidth-1:0] instrAddr;
  logic [cpuPkg::memAddrWidth-1:0] dataAddr;
  logic [cpuPkg::dataWidth-1:0]    dataWdata;
  logic                            dataWeSel;

  // The core owns both memories while a program runs
  assign instrAddr = busy ? pc : hostIndex;
  assign dataAddr  = busy ? coreAddr : hostIndex;
  assign dataWdata = busy ? coreWdata : hostWdata;
  assign dataWeSel = busy ? coreDataWe : dataWe;

  always_ff @(posedge clk) begin
    if (instrWe) begin
      instrMem[hostIndex] <= hostWdata;  // Program load from host only
    end
  end

  always_ff @(posedge clk) begin
    if (dataWeSel) begin
      dataMem[dataAddr] <= dataWdata;
    end
  end

  assign instruction = instrMem[instrAddr];
  assign instrRdata  = instrMem[instrAddr];
  assign coreRdata   = dataMem[dataAddr];
  assign dataRdata   = dataMem[dataAddr];

endmodule

`default_nettype wire

/* logic/registerFile.sv */
// Eight general registers with two core read ports, one write port
// and a host read port
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cpuPkg::regIdxWidth-1:0]   readIdxA,
  input  logic [cpuPkg::regIdxWidth-1:0]   readIdxB,
  output logic [cpuPkg::dataWidth-1:0]     readDataA,
  output logic [cpuPkg::dataWidth-1:0]     readDataB,
  input  logic                             writeEn,
  input  logic [cpuPkg::regIdxWidth-1:0]   writeIdx,
  input  logic [cpuPkg::dataWidth-1:0]     writeData,
  input  logic [cpuPkg::regIdxWidth-1:0]   hostIdx,
  output logic [cpuPkg::dataWidth-1:0]     hostData
);

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpuPkg::regCount; i++) begin
        regs[i] <= cpuPkg::dataWidth'(i);  // Register i starts at i
      end
    end else if (writeEn) begin
      regs[writeIdx] <= writeData;
    end
  end

  assign readDataA = regs[readIdxA];
  assign readDataB = regs[readIdxB];
  assign hostData  = regs[hostIdx];

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
// Multi-cycle FSM with pc, instruction register, decode, operand latches
// and next-pc selection
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  output logic                              busy,
  output logic [cpuPkg::memAddrWidth-1:0]   pc,
  input  logic [cpuPkg::dataWidth-1:0]      instruction,
  output logic [cpuPkg::regIdxWidth-1:0]    readIdxA,
  output logic [cpuPkg::regIdxWidth-1:0]    readIdxB,
  input  logic [cpuPkg::dataWidth-1:0]      readDataA,
  input  logic [cpuPkg::dataWidth-1:0]      readDataB,
  output logic                              regWriteEn,
  output logic [cpuPkg::regIdxWidth-1:0]    regWriteIdx,
  output logic [3:0]                        aluOp,
  output logic [cpuPkg::dataWidth-1:0]      aluA,
  output logic [cpuPkg::dataWidth-1:0]      aluB,
  input  logic [cpuPkg::dataWidth-1:0]      aluResult,
  input  logic                              taken,
  output logic                              memWriteEn,
  output logic [cpuPkg::dataWidth-1:0]      storeData,
  output logic [cpuPkg::dataWidth-1:0]      latchedResult,
  output logic                              useMemData
);

  logic [2:0]                      state;
  cpuPkg::instrWord                ir;
  logic [3:0]                      opcode;
  logic                            isRType;
  logic                            isBranch;
  logic                            isStore;
  logic                            isValid;
  logic [cpuPkg::dataWidth-1:0]    immSext;
  logic [cpuPkg::dataWidth-1:0]    operandB;
  logic [cpuPkg::memAddrWidth-1:0] pcInc;
  logic [cpuPkg::memAddrWidth-1:0] branchTarget;

  assign opcode   = ir.rFormat.opcode;
  assign isRType  = opcode inside {cpuPkg::opAnd, cpuPkg::opAdd, cpuPkg::opSub};
  assign isBranch = opcode inside {cpuPkg::opBgt, cpuPkg::opBlt, cpuPkg::opBeq, cpuPkg::opBne};
  assign isStore  = (opcode == cpuPkg::opSw) || (opcode == cpuPkg::opSv);
  assign isValid  = isRType || isBranch || isStore ||
                    (opcode inside {cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opLw});
  assign immSext  = {{(cpuPkg::dataWidth-5){ir.iFormat.imm[4]}}, ir.iFormat.imm};

  assign pcInc        = pc + 1'b1;
  assign branchTarget = pc + {{(cpuPkg::memAddrWidth-5){ir.iFormat.imm[4]}}, ir.iFormat.imm};

  // Register read indices per format
  always_comb begin
    if (isBranch) begin
      readIdxA = ir.iFormat.rd;  // Branches compare rd first
    end else if (opcode == cpuPkg::opSv) begin
      readIdxA = ir.sFormat.rs1;
    end else if (isRType) begin
      readIdxA = ir.rFormat.rs1;
    end else begin
      readIdxA = ir.iFormat.rs1;
    end
    if (isRType) begin
      readIdxB = ir.rFormat.rs2;
    end else if (isBranch) begin
      readIdxB = ir.iFormat.rs1;
    end else begin
      readIdxB = ir.iFormat.rd;  // SW store data
    end
  end

  always_comb begin
    if (isRType) begin
      operandB = readDataB;
    end else if (opcode == cpuPkg::opAndi) begin
      operandB = {{(cpuPkg::dataWidth-5){1'b0}}, ir.iFormat.imm};
    end else if (isBranch) begin
      operandB = ir.iFormat.mode ? '0 : readDataB;  // Zero compare mode
    end else if (opcode == cpuPkg::opSv) begin
      operandB = '0;  // Address is the register itself
    end else begin
      operandB = immSext;
    end
  end

  // Payload latches
  always_ff @(posedge clk) begin
    if (state == cpuPkg::stFetch) begin
      ir <= instruction;
    end
    if (state == cpuPkg::stDecode) begin
      aluA      <= readDataA;
      aluB      <= operandB;
      storeData <= (opcode == cpuPkg::opSv) ?
                   {{(cpuPkg::dataWidth-9){1'b0}}, ir.sFormat.imm} : readDataB;
    end
    if (state == cpuPkg::stExecute) begin
      latchedResult <= aluResult;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cpuPkg::stIdle;
      pc    <= '0;
    end else begin
      case (state)
        cpuPkg::stIdle: begin
          if (start) begin
            state <= cpuPkg::stFetch;
            pc    <= '0;
          end
        end
        cpuPkg::stFetch: state <= cpuPkg::stDecode;
        cpuPkg::stDecode: begin
          if (opcode == cpuPkg::opJmp) begin
            pc    <= ir.jFormat.offset[cpuPkg::memAddrWidth-1:0];
            state <= cpuPkg::stFetch;
          end else if (opcode == cpuPkg::opHalt) begin
            state <= cpuPkg::stIdle;
          end else if (!isValid) begin
            pc    <= pcInc;  // Unused opcodes act as no-ops
            state <= cpuPkg::stFetch;
          end else begin
            state <= cpuPkg::stExecute;
          end
        end
        cpuPkg::stExecute: begin
          if (isBranch) begin
            pc    <= taken ? branchTarget : pcInc;
            state <= cpuPkg::stFetch;
          end else begin
            state <= cpuPkg::stMemory;
          end
        end
        cpuPkg::stMemory: begin
          if (isStore) begin
            pc    <= pcInc;
            state <= cpuPkg::stFetch;
          end else begin
            state <= cpuPkg::stWriteBack;
          end
        end
        cpuPkg::stWriteBack: begin
          pc    <= pcInc;
          state <= cpuPkg::stFetch;
        end
        default: state <= cpuPkg::stIdle;
      endcase
    end
  end

  assign busy        = (state != cpuPkg::stIdle);
  assign aluOp       = opcode;
  assign regWriteEn  = (state == cpuPkg::stWriteBack);
  assign regWriteIdx = isRType ? ir.rFormat.rd : ir.iFormat.rd;
  assign memWriteEn  = (state == cpuPkg::stMemory) && isStore;
  assign useMemData  = (opcode == cpuPkg::opLw);

endmodule

`default_nettype wire

/* logic/cpuTop.sv */
// Processor top level with APB host port and write-back data mux
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [cpuPkg::apbAddrWidth-1:0]   paddr,
  input  logic [cpuPkg::dataWidth-1:0]      pwdata,
  output logic [cpuPkg::dataWidth-1:0]      prdata,
  output logic                              pready,
  output logic                              pslverr
);

  logic                            busy;
  logic                            start;
  logic                            instrWe;
  logic                            dataWe;
  logic [cpuPkg::memAddrWidth-1:0] hostIndex;
  logic [cpuPkg::dataWidth-1:0]    hostWdata;
  logic [cpuPkg::dataWidth-1:0]    instrRdata;
  logic [cpuPkg::dataWidth-1:0]    dataRdata;
  logic [cpuPkg::dataWidth-1:0]    regRdata;
  logic [cpuPkg::memAddrWidth-1:0] pc;
  logic [cpuPkg::dataWidth-1:0]    instruction;
  logic [cpuPkg::regIdxWidth-1:0]  readIdxA;
  logic [cpuPkg::regIdxWidth-1:0]  readIdxB;
  logic [cpuPkg::dataWidth-1:0]    readDataA;
  logic [cpuPkg::dataWidth-1:0]    readDataB;
  logic                            regWriteEn;
  logic [cpuPkg::regIdxWidth-1:0]  regWriteIdx;
  logic [cpuPkg::dataWidth-1:0]    writeBackData;
  logic [3:0]                      aluOp;
  logic [cpuPkg::dataWidth-1:0]    aluA;
  logic [cpuPkg::dataWidth-1:0]    aluB;
  logic [cpuPkg::dataWidth-1:0]    aluResult;
  logic                            taken;
  logic                            memWriteEn;
  logic [cpuPkg::dataWidth-1:0]    storeData;
  logic [cpuPkg::dataWidth-1:0]    latchedResult;
  logic [cpuPkg::dataWidth-1:0]    coreRdata;
  logic                            useMemData;

  assign writeBackData = useMemData ? coreRdata : latchedResult;  // LW takes the memory word

  apbSlave i_apbSlave (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .busy(busy), .start(start), .instrWe(instrWe),
    .dataWe(dataWe), .hostIndex(hostIndex), .hostWdata(hostWdata),
    .instrRdata(instrRdata), .dataRdata(dataRdata), .regRdata(regRdata)
  );

  memorySystem i_memorySystem (
    .clk(clk), .instrWe(instrWe), .dataWe(dataWe), .hostIndex(hostIndex),
    .hostWdata(hostWdata), .instrRdata(instrRdata), .dataRdata(dataRdata),
    .pc(pc), .instruction(instruction), .coreDataWe(memWriteEn),
    .coreAddr(latchedResult[cpuPkg::memAddrWidth-1:0]), .coreWdata(storeData),
    .coreRdata(coreRdata), .busy(busy)
  );

  registerFile i_registerFile (
    .clk(clk), .reset(reset), .readIdxA(readIdxA), .readIdxB(readIdxB),
    .readDataA(readDataA), .readDataB(readDataB), .writeEn(regWriteEn),
    .writeIdx(regWriteIdx), .writeData(writeBackData),
    .hostIdx(hostIndex[cpuPkg::regIdxWidth-1:0]), .hostData(regRdata)
  );

  controlUnit i_controlUnit (
    .clk(clk), .reset(reset), .start(start), .busy(busy), .pc(pc),
    .instruction(instruction), .readIdxA(readIdxA), .readIdxB(readIdxB),
    .readDataA(readDataA), .readDataB(readDataB), .regWriteEn(regWriteEn),
    .regWriteIdx(regWriteIdx), .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
    .aluResult(aluResult), .taken(taken), .memWriteEn(memWriteEn),
    .storeData(storeData), .latchedResult(latchedResult), .useMemData(useMemData)
  );

  alu i_alu (
    .aluOp(aluOp), .a(aluA), .b(aluB), .result(aluResult), .taken(taken)
  );

endmodule

`default_nettype wire

/* tb/tbModel.svh */
// APB transfer tasks, random program generator and the reference model
// of registers and data memory
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0] progWords [256];
logic [15:0] modelRegs [8];
logic [15:0] modelDmem [256];

function automatic logic [11:0] regionAddr(input logic [1:0] region, input logic [7:0] index);
  return {2'b00, region, index};
endfunction

function automatic int randBelow(input int limit);
  return int'($unsigned($random(seed)) % limit);
endfunction

// Setup cycle, then access cycle; responses sampled mid access cycle
task apbTransfer(input logic write, input logic [11:0] addr, input logic [15:0] wdata,
                 output logic [15:0] rdata, output logic err);
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= write;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge clk);
  penable <= 1'b1;
  @(negedge clk);
  rdata = prdata;
  err   = pslverr;
  checkValue("pready", 16'h0001, 16'(pready));
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task writeChecked(input string testName, input logic [11:0] addr, input logic [15:0] data);
  logic [15:0] rdata;
  logic        err;
  apbTransfer(1'b1, addr, data, rdata, err);
  checkValue(testName, 16'h0000, 16'(err));
endtask

task readChecked(input string testName, input logic [11:0] addr, input logic [15:0] expected);
  logic [15:0] rdata;
  logic        err;
  apbTransfer(1'b0, addr, 16'h0000, rdata, err);
  checkValue(testName, 16'h0000, 16'(err));
  checkValue(testName, expected, rdata);
endtask

task expectError(input string testName, input logic write, input logic [11:0] addr,
                 input logic [15:0] wdata);
  logic [15:0] rdata;
  logic        err;
  apbTransfer(write, addr, wdata, rdata, err);
  checkValue(testName, 16'h0001, 16'(err));
endtask

task waitIdle();
  logic [15:0] status;
  logic        err;
  status = 16'h0001;
  while (status[0]) begin
    apbTransfer(1'b0, ctrlAddr, 16'h0000, status, err);
    checkValue("status poll", 16'h0000, 16'(err));
  end
endtask

task loadProgram(input int len);
  for (int i = 0; i <= len; i++) begin
    writeChecked("program load", regionAddr(cpuPkg::regionInstr, 8'(i)), progWords[i]);
  end
endtask

task loadDataMemory();
  logic [15:0] word;
  for (int i = 0; i < cpuPkg::memDepth; i++) begin
    word = 16'($random(seed));
    writeChecked("data load", regionAddr(cpuPkg::regionData, 8'(i)), word);
    modelDmem[i] = word;
  end
endtask

task checkRegisters(input string testName);
  for (int i = 0; i < cpuPkg::regCount; i++) begin
    readChecked(testName, regionAddr(cpuPkg::regionRegs, 8'(i)), modelRegs[i]);
  end
endtask

task checkDataMemory(input string testName);
  for (int i = 0; i < cpuPkg::memDepth; i++) begin
    readChecked(testName, regionAddr(cpuPkg::regionData, 8'(i)), modelDmem[i]);
  end
endtask

function automatic logic [3:0] chooseOp(input int kind);
  logic [3:0] aluOps [5];
  logic [3:0] memOps [6];
  logic [3:0] flowOps [8];
  aluOps  = '{cpuPkg::opAnd, cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAddi, cpuPkg::opAndi};
  memOps  = '{cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opLw, cpuPkg::opSw, cpuPkg::opSv,
              cpuPkg::opLw};
  flowOps = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAddi, cpuPkg::opBgt, cpuPkg::opBlt,
              cpuPkg::opBeq, cpuPkg::opBne, cpuPkg::opJmp};
  case (kind)
    kindAlu:    return aluOps[randBelow(5)];
    kindMemory: return memOps[randBelow(6)];
    default:    return flowOps[randBelow(8)];
  endcase
endfunction

// Branches and jumps only go forward, so every program reaches its HALT
task makeProgram(input int kind, input int len);
  logic [3:0]  op;
  logic [11:0] body;
  int          reach;
  for (int p = 0; p < len; p++) begin
    op   = chooseOp(kind);
    body = 12'($random(seed));
    if (op inside {cpuPkg::opBgt, cpuPkg::opBlt, cpuPkg::opBeq, cpuPkg::opBne}) begin
      reach     = (len - p > 15) ? 15 : len - p;
      body[4:0] = 5'(1 + randBelow(reach));
    end else if (op == cpuPkg::opJmp) begin
      body = 12'(p + 1 + randBelow(len - p));  // Target up to the HALT
    end
    progWords[p] = {op, body};
  end
  progWords[len] = {cpuPkg::opHalt, 12'h000};
endtask

task executeModel();
  logic [7:0]  pc;
  logic [7:0]  addr;
  logic [15:0] w;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] sext;
  logic        taken;
  int          steps;
  pc    = 8'h00;
  steps = 0;
  while (progWords[pc][15:12] != cpuPkg::opHalt) begin
    w     = progWords[pc];
    sext  = {{11{w[4]}}, w[4:0]};
    a     = modelRegs[w[10:8]];
    b     = w[11] ? 16'h0000 : modelRegs[w[7:5]];  // Mode bit selects the zero compare
    addr  = 8'(modelRegs[w[7:5]] + sext);
    taken = 1'b0;
    case (w[15:12])
      cpuPkg::opAnd:  modelRegs[w[11:9]] = modelRegs[w[8:6]] & modelRegs[w[5:3]];
      cpuPkg::opAdd:  modelRegs[w[11:9]] = modelRegs[w[8:6]] + modelRegs[w[5:3]];
      cpuPkg::opSub:  modelRegs[w[11:9]] = modelRegs[w[8:6]] - modelRegs[w[5:3]];
      cpuPkg::opAddi: modelRegs[w[10:8]] = modelRegs[w[7:5]] + sext;
      cpuPkg::opAndi: modelRegs[w[10:8]] = modelRegs[w[7:5]] & {11'h000, w[4:0]};
      cpuPkg::opLw:   modelRegs[w[10:8]] = modelDmem[addr];
      cpuPkg::opSw:   modelDmem[addr] = modelRegs[w[10:8]];
      cpuPkg::opSv:   modelDmem[modelRegs[w[11:9]][7:0]] = {7'h00, w[8:0]};
      cpuPkg::opBgt:  taken = (a > b);
      cpuPkg::opBlt:  taken = (a < b);
      cpuPkg::opBeq:  taken = (a == b);
      cpuPkg::opBne:  taken = (a != b);
      default: ;
    endcase
    if (w[15:12] == cpuPkg::opJmp) begin
      pc = w[7:0];
    end else if (taken) begin
      pc = pc + sext[7:0];
    end else begin
      pc = pc + 8'd1;
    end
    steps++;
    if (steps > programLen + 1) begin
      $display("The reference model did not reach the HALT of its program");
      abortRun();
    end
  end
endtask

task runProgram();
  writeChecked("start", ctrlAddr, 16'h0001);
  waitIdle();
  executeModel();
endtask

`endif

/* tb/tbCpu.sv */
// Testbench for the multi-cycle processor with clock, reset, test sequence,
// timeout and the final report
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

  localparam int resetCycles    = 8;
  localparam int programLen     = 16;  // Instructions before the HALT
  localparam int aluPrograms    = 6;
  localparam int memPrograms    = 6;
  localparam int branchPrograms = 8;
  localparam int busyPrograms   = 2;
  localparam int totalPrograms  = aluPrograms + memPrograms + branchPrograms + busyPrograms;
  // Each program gets its worst-case run time plus 600 cycles of APB traffic
  localparam int timeoutCycles  = totalPrograms * ((programLen + 1) * 5 + 600) + resetCycles;
  localparam int kindAlu        = 0;
  localparam int kindMemory     = 1;
  localparam int kindFlow       = 2;
  localparam logic [cpuPkg::apbAddrWidth-1:0] ctrlAddr =
    {2'b00, cpuPkg::regionCtrl, cpuPkg::ctrlIndex};

  logic                             clk;
  logic                             reset;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [cpuPkg::apbAddrWidth-1:0]  paddr;
  logic [cpuPkg::dataWidth-1:0]     pwdata;
  logic [cpuPkg::dataWidth-1:0]     prdata;
  logic                             pready;
  logic                             pslverr;
  integer                           seed;
  int                               cycleCount;

  cpuTop i_cpuTop (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic abortRun();
    $display("TB FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkValue(input string testName, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %h, actual %h", testName, expected, actual);
      abortRun();
    end
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the run took more than %0d cycles", timeoutCycles);
      abortRun();
    end
  end

  `include "tbModel.svh"

  initial begin
    logic [15:0] word;
    logic [7:0]  index;
    seed       = 32'h6c53;
    cycleCount = 0;
    clk        = 1'b0;
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    for (int i = 0; i < cpuPkg::regCount; i++) begin
      modelRegs[i] = 16'(i);
    end
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;

    readChecked("reset status", ctrlAddr, 16'h0000);
    checkRegisters("reset registers");

    for (int i = 0; i < 32; i++) begin
      index = 8'($random(seed));
      word  = 16'($random(seed));
      writeChecked("instr write", regionAddr(cpuPkg::regionInstr, index), word);
      readChecked("instr readback", regionAddr(cpuPkg::regionInstr, index), word);
      index = 8'($random(seed));
      word  = 16'($random(seed));
      writeChecked("data write", regionAddr(cpuPkg::regionData, index), word);
      modelDmem[index] = word;
      readChecked("data readback", regionAddr(cpuPkg::regionData, index), word);
    end
    expectError("register write", 1'b1, regionAddr(cpuPkg::regionRegs, 8'd3), 16'hffff);
    readChecked("register unchanged", regionAddr(cpuPkg::regionRegs, 8'd3), modelRegs[3]);
    expectError("register index", 1'b0,
                regionAddr(cpuPkg::regionRegs, 8'(8 + randBelow(248))), 16'h0000);
    expectError("control index", 1'b1,
                regionAddr(cpuPkg::regionCtrl, 8'(1 + randBelow(255))), 16'h0001);
    readChecked("status after bad start", ctrlAddr, 16'h0000);

    for (int n = 0; n < aluPrograms; n++) begin
      makeProgram(kindAlu, programLen);
      loadProgram(programLen);
      runProgram();
      checkRegisters("alu program");
    end

    loadDataMemory();
    for (int n = 0; n < memPrograms; n++) begin
      makeProgram(kindMemory, programLen);
      loadProgram(programLen);
      runProgram();
      checkRegisters("memory program registers");
      checkDataMemory("memory program data");
    end

    for (int n = 0; n < branchPrograms; n++) begin
      makeProgram(kindFlow, programLen);
      loadProgram(programLen);
      runProgram();
      checkRegisters("branch program");
    end

    // Host accesses while the core owns the memories
    for (int n = 0; n < busyPrograms; n++) begin
      makeProgram(kindAlu, programLen);
      loadProgram(programLen);
      writeChecked("start", ctrlAddr, 16'h0001);
      readChecked("busy status", ctrlAddr, 16'h0001);
      index = 8'(randBelow(programLen + 1));
      word  = 16'($random(seed));
      expectError("busy instr write", 1'b1, regionAddr(cpuPkg::regionInstr, index), word);
      expectError("busy instr read", 1'b0, regionAddr(cpuPkg::regionInstr, index), 16'h0);
      expectError("busy data write", 1'b1, regionAddr(cpuPkg::regionData, index), word);
      expectError("busy data read", 1'b0, regionAddr(cpuPkg::regionData, index), 16'h0);
      expectError("busy start", 1'b1, ctrlAddr, 16'h0001);
      waitIdle();
      executeModel();
      checkRegisters("busy program");
      readChecked("instr kept", regionAddr(cpuPkg::regionInstr, index), progWords[index]);
      readChecked("data kept", regionAddr(cpuPkg::regionData, index), modelDmem[index]);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tb
logic/cpuPkg.sv
logic/alu.sv
logic/apbSlave.sv
logic/memorySystem.sv
logic/registerFile.sv
logic/controlUnit.sv
logic/cpuTop.sv
tb/tbCpu.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the processor testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module tbCpu -Mdir "$buildDir" -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/VtbCpu" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "TB FAILED" "$logFile"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi
if ! grep -q "TB PASSED" "$logFile"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
exit 0
